//--- logic/exec_op_pkg.sv
`default_nettype none

package exec_op_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;

    // Operations handed over by decode
    typedef enum logic [5:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        ECALL, EBREAK
    } op_e;

    function automatic logic is_store(op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic logic is_load(op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    // Conditional branches only
    function automatic logic is_branch(op_e op);
        return op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
    endfunction

endpackage

`default_nettype wire

//--- logic/exec_trap_pkg.sv
`default_nettype none

package exec_trap_pkg;

    // Machine cause codes for synchronous exceptions
    typedef enum logic [3:0] {
        INSTR_MISALIGNED  = 4'd0,
        ILLEGAL_INSTR     = 4'd2,
        BREAKPOINT        = 4'd3,
        LOAD_ACCESS_FAULT = 4'd5,
        ECALL_M           = 4'd11,
        NONE              = 4'd15
    } exc_code_e;

    // Flow tag width used unless the top level overrides it
    localparam int TAG_W_DEFAULT = 3;

endpackage

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_op_pkg::op_e    op_i,
    input  exec_op_pkg::word_t  op_a_i,
    input  exec_op_pkg::word_t  op_b_i,
    input  exec_op_pkg::word_t  op_c_i,
    input  exec_op_pkg::word_t  pc_i,
    output exec_op_pkg::word_t  sum_o,
    output exec_op_pkg::word_t  result_o,
    output logic                eq_o,
    output logic                lt_o,
    output logic                ltu_o
);

    exec_op_pkg::shamt_t shamt;
    exec_op_pkg::word_t  add2_a;
    exec_op_pkg::word_t  add2_b;
    exec_op_pkg::word_t  add2;

    assign shamt = op_b_i[4:0];
    assign sum_o = op_a_i + op_b_i;

    // Second adder shared by subtract, link address and pc-relative offset
    always_comb begin
        add2_a = (op_i == exec_op_pkg::SUB) ? op_a_i : pc_i;
        case (op_i)
            exec_op_pkg::JAL,
            exec_op_pkg::JALR: add2_b = 32'd4;
            exec_op_pkg::SUB:  add2_b = ~op_b_i + 32'd1;
            default:           add2_b = op_c_i;
        endcase
    end

    assign add2 = add2_a + add2_b;

    assign eq_o  = (op_a_i == op_b_i);
    assign lt_o  = ($signed(op_a_i) < $signed(op_b_i));
    assign ltu_o = (op_a_i < op_b_i);

    always_comb begin
        case (op_i)
            exec_op_pkg::SUB,
            exec_op_pkg::JAL,
            exec_op_pkg::JALR: result_o = add2;
            exec_op_pkg::AND:  result_o = op_a_i & op_b_i;
            exec_op_pkg::OR:   result_o = op_a_i | op_b_i;
            exec_op_pkg::XOR:  result_o = op_a_i ^ op_b_i;
            exec_op_pkg::SLL:  result_o = op_a_i << shamt;
            exec_op_pkg::SRL:  result_o = op_a_i >> shamt;
            exec_op_pkg::SRA:  result_o = $signed(op_a_i) >>> shamt;
            exec_op_pkg::SLT:  result_o = {31'b0, lt_o};
            exec_op_pkg::SLTU: result_o = {31'b0, ltu_o};
            exec_op_pkg::LUI:  result_o = op_b_i;
            default: begin
                // Branches carry pc + offset
                result_o = exec_op_pkg::is_branch(op_i) ? add2 : sum_o;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  exec_op_pkg::op_e    op_i,
    input  exec_op_pkg::word_t  sum_i,
    input  exec_op_pkg::word_t  pc_i,
    input  exec_op_pkg::word_t  op_c_i,
    input  logic                eq_i,
    input  logic                lt_i,
    input  logic                ltu_i,
    output logic                taken_o,
    output exec_op_pkg::word_t  target_o
);

    logic cond;

    // Condition per branch type
    always_comb begin
        case (op_i)
            exec_op_pkg::BEQ:  cond = eq_i;
            exec_op_pkg::BNE:  cond = ~eq_i;
            exec_op_pkg::BLT:  cond = lt_i;
            exec_op_pkg::BLTU: cond = ltu_i;
            exec_op_pkg::BGE:  cond = ~lt_i;
            exec_op_pkg::BGEU: cond = ~ltu_i;
            default:           cond = 1'b0;
        endcase
    end

    assign taken_o = (exec_op_pkg::is_branch(op_i) & cond)
                   | (op_i inside {exec_op_pkg::JAL, exec_op_pkg::JALR});

    always_comb begin
        case (op_i)
            exec_op_pkg::JAL:  target_o = sum_i;
            exec_op_pkg::JALR: target_o = {sum_i[31:1], 1'b0};
            default:           target_o = pc_i + op_c_i;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/lsu_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_lanes (
    input  exec_op_pkg::op_e    op_i,
    input  exec_op_pkg::word_t  sum_i,
    input  exec_op_pkg::word_t  op_c_i,
    output exec_op_pkg::word_t  address_o,
    output exec_op_pkg::word_t  write_data_o,
    output logic                read_o,
    output logic [3:0]          strobe_o,
    output logic                access_o
);

    // Memory is word addressed
    assign address_o = {sum_i[31:2], 2'b00};
    assign read_o    = exec_op_pkg::is_load(op_i);

    always_comb begin
        case (op_i)
            exec_op_pkg::SB: write_data_o = {4{op_c_i[7:0]}};
            exec_op_pkg::SH: write_data_o = {2{op_c_i[15:0]}};
            default:         write_data_o = op_c_i;
        endcase
    end

    always_comb begin
        case (op_i)
            exec_op_pkg::SB: begin
                case (sum_i[1:0])
                    2'b00:   strobe_o = 4'b0001;
                    2'b01:   strobe_o = 4'b0010;
                    2'b10:   strobe_o = 4'b0100;
                    default: strobe_o = 4'b1000;
                endcase
            end
            exec_op_pkg::SH: strobe_o = sum_i[1] ? 4'b1100 : 4'b0011;
            exec_op_pkg::SW: strobe_o = 4'b1111;
            default:         strobe_o = 4'b0000;
        endcase
    end

    assign access_o = read_o | (strobe_o != 4'b0000);

endmodule

`default_nettype wire

//--- logic/flow_tag.sv
`timescale 1ns/1ps
`default_nettype none

module flow_tag #(
    parameter int TAG_W = exec_trap_pkg::TAG_W_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [TAG_W-1:0] tag_i,
    input  logic             advance_i,
    output logic             killed_o
);

    logic [TAG_W-1:0] curr_tag;

    // A new flow starts after every jump or trap
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (advance_i) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    // Stale tag means wrong-path instruction
    assign killed_o = (tag_i != curr_tag);

    a_advance_current: assert property (@(posedge clk) disable iff (reset)
        advance_i |-> !killed_o)
        else $error("flow_tag: advance from a wrong-path instruction");

endmodule

`default_nettype wire

//--- logic/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  exec_op_pkg::op_e          op_i,
    input  logic                      killed_i,
    input  logic                      exc_illegal_i,
    input  logic                      exc_misaligned_i,
    input  logic                      exc_mem_fault_i,
    input  logic                      access_i,
    output logic                      raise_o,
    output exec_trap_pkg::exc_code_e  code_o
);

    // Highest priority first
    always_comb begin
        raise_o = 1'b1;
        if (killed_i) begin
            // Wrong-path instructions never trap
            raise_o = 1'b0;
            code_o  = exec_trap_pkg::NONE;
        end else if (exc_illegal_i) begin
            code_o  = exec_trap_pkg::ILLEGAL_INSTR;
        end else if (exc_misaligned_i) begin
            code_o  = exec_trap_pkg::INSTR_MISALIGNED;
        end else if (op_i == exec_op_pkg::ECALL) begin
            code_o  = exec_trap_pkg::ECALL_M;
        end else if (op_i == exec_op_pkg::EBREAK) begin
            code_o  = exec_trap_pkg::BREAKPOINT;
        end else if (exc_mem_fault_i && access_i) begin
            // Fault only counts for an actual load or store
            code_o  = exec_trap_pkg::LOAD_ACCESS_FAULT;
        end else begin
            raise_o = 1'b0;
            code_o  = exec_trap_pkg::NONE;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute #(
    parameter int TAG_W = exec_trap_pkg::TAG_W_DEFAULT
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  exec_op_pkg::word_t        pc_i,
    input  exec_op_pkg::word_t        op_a_i,
    input  exec_op_pkg::word_t        op_b_i,
    input  exec_op_pkg::word_t        op_c_i,
    input  exec_op_pkg::op_e          op_i,
    input  logic [TAG_W-1:0]          tag_i,
    input  logic                      exc_illegal_i,
    input  logic                      exc_misaligned_i,
    input  logic                      exc_mem_fault_i,
    output logic                      killed_o,
    output logic                      write_enable_o,
    output exec_op_pkg::op_e          op_o,
    output exec_op_pkg::word_t        result_o,
    output exec_op_pkg::word_t        mem_address_o,
    output logic                      mem_read_o,
    output logic [3:0]                mem_strobe_o,
    output exec_op_pkg::word_t        mem_write_data_o,
    output logic                      jump_o,
    output exec_op_pkg::word_t        jump_target_o,
    output logic                      raise_exception_o,
    output exec_trap_pkg::exc_code_e  exception_code_o
);

    exec_op_pkg::word_t sum;
    exec_op_pkg::word_t result;
    logic               eq;
    logic               lt;
    logic               ltu;
    logic               taken;
    logic               access;
    logic               advance;
    logic               write_enable;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath units
    ////////////////////////////////////////////////////////////////////////////

    alu alu0 (
        .op_i     (op_i),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .op_c_i   (op_c_i),
        .pc_i     (pc_i),
        .sum_o    (sum),
        .result_o (result),
        .eq_o     (eq),
        .lt_o     (lt),
        .ltu_o    (ltu)
    );

    branch_unit branch0 (
        .op_i     (op_i),
        .sum_i    (sum),
        .pc_i     (pc_i),
        .op_c_i   (op_c_i),
        .eq_i     (eq),
        .lt_i     (lt),
        .ltu_i    (ltu),
        .taken_o  (taken),
        .target_o (jump_target_o)
    );

    lsu_lanes lsu0 (
        .op_i         (op_i),
        .sum_i        (sum),
        .op_c_i       (op_c_i),
        .address_o    (mem_address_o),
        .write_data_o (mem_write_data_o),
        .read_o       (mem_read_o),
        .strobe_o     (mem_strobe_o),
        .access_o     (access)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Flow control and traps
    ////////////////////////////////////////////////////////////////////////////

    trap_ctrl trap0 (
        .op_i             (op_i),
        .killed_i         (killed_o),
        .exc_illegal_i    (exc_illegal_i),
        .exc_misaligned_i (exc_misaligned_i),
        .exc_mem_fault_i  (exc_mem_fault_i),
        .access_i         (access),
        .raise_o          (raise_exception_o),
        .code_o           (exception_code_o)
    );

    flow_tag #(
        .TAG_W (TAG_W)
    ) tag0 (
        .clk       (clk),
        .reset     (reset),
        .tag_i     (tag_i),
        .advance_i (advance),
        .killed_o  (killed_o)
    );

    // A trap wins over a jump from the same instruction
    assign jump_o  = taken & ~killed_o & ~raise_exception_o;
    assign advance = jump_o | raise_exception_o;

    // Stores and branches leave the register file alone
    assign write_enable = (exec_op_pkg::is_store(op_i) | exec_op_pkg::is_branch(op_i))
                        ? 1'b0
                        : ~(killed_o | raise_exception_o);

    ////////////////////////////////////////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
            op_o           <= exec_op_pkg::NOP;
            result_o       <= '0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= result;
        end
    end

    a_fault_needs_access: assert property (@(posedge clk) disable iff (reset)
        exception_code_o == exec_trap_pkg::LOAD_ACCESS_FAULT
            |-> (mem_read_o || mem_strobe_o != 4'b0000))
        else $error("execute: access fault without a memory access");

endmodule

`default_nettype wire

//--- test/execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

    localparam int TAG_W = 3;
    // Tests need about 90 cycles including reset
    localparam int TIMEOUT_CYCLES = 400;

    typedef exec_op_pkg::word_t word_t;

    logic                     clk;
    logic                     reset;
    logic                     stall;
    word_t                    pc;
    word_t                    op_a;
    word_t                    op_b;
    word_t                    op_c;
    exec_op_pkg::op_e         op;
    logic [TAG_W-1:0]         tag;
    logic                     exc_illegal;
    logic                     exc_misaligned;
    logic                     exc_mem_fault;
    logic                     killed;
    logic                     write_enable;
    exec_op_pkg::op_e         op_out;
    word_t                    result;
    word_t                    mem_address;
    logic                     mem_read;
    logic [3:0]               mem_strobe;
    word_t                    mem_write_data;
    logic                     jump;
    word_t                    jump_target;
    logic                     raise_exc;
    exec_trap_pkg::exc_code_e exc_code;

    logic [TAG_W-1:0] exp_tag;
    word_t            rng;
    int               errors;
    int               checks;
    int               cycles;

    execute #(.TAG_W(TAG_W)) dut0 (
        .clk (clk), .reset (reset), .stall_i (stall),
        .pc_i (pc), .op_a_i (op_a), .op_b_i (op_b), .op_c_i (op_c),
        .op_i (op), .tag_i (tag),
        .exc_illegal_i (exc_illegal), .exc_misaligned_i (exc_misaligned),
        .exc_mem_fault_i (exc_mem_fault),
        .killed_o (killed), .write_enable_o (write_enable), .op_o (op_out),
        .result_o (result), .mem_address_o (mem_address), .mem_read_o (mem_read),
        .mem_strobe_o (mem_strobe), .mem_write_data_o (mem_write_data),
        .jump_o (jump), .jump_target_o (jump_target),
        .raise_exception_o (raise_exc), .exception_code_o (exc_code)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t alu_expect(exec_op_pkg::op_e o, word_t a, word_t b);
        case (o)
            exec_op_pkg::ADD:  return a + b;
            exec_op_pkg::SUB:  return a - b;
            exec_op_pkg::AND:  return a & b;
            exec_op_pkg::OR:   return a | b;
            exec_op_pkg::XOR:  return a ^ b;
            exec_op_pkg::SLL:  return a << b[4:0];
            exec_op_pkg::SRL:  return a >> b[4:0];
            exec_op_pkg::SRA:  return word_t'($signed(a) >>> b[4:0]);
            exec_op_pkg::SLT:  return {31'b0, $signed(a) < $signed(b)};
            exec_op_pkg::SLTU: return {31'b0, a < b};
            exec_op_pkg::LUI:  return b;
            default:           return '0;
        endcase
    endfunction

    function automatic logic branch_expect(exec_op_pkg::op_e o, word_t a, word_t b);
        case (o)
            exec_op_pkg::BEQ:  return a == b;
            exec_op_pkg::BNE:  return a != b;
            exec_op_pkg::BLT:  return $signed(a) < $signed(b);
            exec_op_pkg::BLTU: return a < b;
            exec_op_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_op_pkg::BGEU: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] strobe_expect(exec_op_pkg::op_e o, logic [1:0] lo);
        case (o)
            exec_op_pkg::SB: return 4'b0001 << lo;
            exec_op_pkg::SH: return lo[1] ? 4'b1100 : 4'b0011;
            exec_op_pkg::SW: return 4'b1111;
            default:         return 4'b0000;
        endcase
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Drives one instruction with the current tag 1 ns after a rising edge
    task automatic drive(input exec_op_pkg::op_e o, input word_t a, input word_t b,
                         input word_t c);
        op             = o;
        op_a           = a;
        op_b           = b;
        op_c           = c;
        pc             = rand_word() & 32'hffff_fffc;
        tag            = exp_tag;
        stall          = 1'b0;
        exc_illegal    = 1'b0;
        exc_misaligned = 1'b0;
        exc_mem_fault  = 1'b0;
    endtask

    // Takes the edge, checks the register and moves the tag model on
    task automatic commit(input logic exp_we, input logic advance);
        @(posedge clk);
        #1;
        compare("write_enable_o", 32'(write_enable), 32'(exp_we));
        compare("op_o", 32'(op_out), 32'(op));
        if (advance) begin
            exp_tag = exp_tag + 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic alu_tests();
        exec_op_pkg::op_e ops[11];
        word_t            a;
        word_t            b;
        ops = '{exec_op_pkg::ADD, exec_op_pkg::SUB, exec_op_pkg::AND, exec_op_pkg::OR,
                exec_op_pkg::XOR, exec_op_pkg::SLL, exec_op_pkg::SRL, exec_op_pkg::SRA,
                exec_op_pkg::SLT, exec_op_pkg::SLTU, exec_op_pkg::LUI};
        foreach (ops[i]) begin
            repeat (3) begin
                a = rand_word();
                b = rand_word();
                drive(ops[i], a, b, rand_word());
                commit(1'b1, 1'b0);
                compare("result_o", result, alu_expect(ops[i], a, b));
            end
        end
    endtask

    task automatic branch_tests();
        exec_op_pkg::op_e ops[6];
        word_t            a;
        word_t            b;
        word_t            c;
        logic             taken;
        ops = '{exec_op_pkg::BEQ, exec_op_pkg::BNE, exec_op_pkg::BLT,
                exec_op_pkg::BLTU, exec_op_pkg::BGE, exec_op_pkg::BGEU};
        foreach (ops[i]) begin
            for (int k = 0; k < 3; k++) begin
                a = rand_word();
                b = (k == 0) ? a : rand_word();
                c = rand_word() & 32'h0000_0ffe;
                if (k == 2) begin
                    drive(ops[i], b, a, c);
                    taken = branch_expect(ops[i], b, a);
                end else begin
                    drive(ops[i], a, b, c);
                    taken = branch_expect(ops[i], a, b);
                end
                @(negedge clk);
                compare("jump_o", 32'(jump), 32'(taken));
                if (taken) begin
                    compare("jump_target_o", jump_target, pc + c);
                end
                commit(1'b0, taken);
            end
        end
        // Jumps are always taken and link pc + 4
        a = rand_word();
        b = rand_word() & 32'h0000_0fff;
        drive(exec_op_pkg::JAL, a, b, '0);
        @(negedge clk);
        compare("jump_o", 32'(jump), 32'd1);
        compare("jump_target_o", jump_target, a + b);
        commit(1'b1, 1'b1);
        compare("result_o", result, pc + 32'd4);
        // Even base makes the raw sum odd
        a = a & ~32'd1;
        drive(exec_op_pkg::JALR, a, b | 32'd1, '0);
        @(negedge clk);
        compare("jump_o", 32'(jump), 32'd1);
        compare("jump_target_o", jump_target, (a + (b | 32'd1)) & ~32'd1);
        commit(1'b1, 1'b1);
        compare("result_o", result, pc + 32'd4);
        // Wrong-path instructions still carry the tag from before the jump
        drive(exec_op_pkg::ADD, a, b, '0);
        tag = exp_tag - 1'b1;
        @(negedge clk);
        compare("killed_o", 32'(killed), 32'd1);
        commit(1'b0, 1'b0);
        drive(exec_op_pkg::BEQ, a, a, 32'd8);
        tag = exp_tag - 1'b1;
        @(negedge clk);
        compare("killed_o", 32'(killed), 32'd1);
        compare("jump_o", 32'(jump), 32'd0);
        commit(1'b0, 1'b0);
    endtask

    task automatic mem_tests();
        exec_op_pkg::op_e ops[12];
        logic [1:0]       offs[12];
        word_t            a;
        word_t            b;
        word_t            c;
        word_t            addr;
        word_t            data;
        logic             load;
        ops  = '{exec_op_pkg::SB, exec_op_pkg::SB, exec_op_pkg::SB, exec_op_pkg::SB,
                 exec_op_pkg::SH, exec_op_pkg::SH, exec_op_pkg::SW, exec_op_pkg::LB,
                 exec_op_pkg::LBU, exec_op_pkg::LH, exec_op_pkg::LHU, exec_op_pkg::LW};
        offs = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0, 2'd1, 2'd3, 2'd2, 2'd0, 2'd0};
        foreach (ops[i]) begin
            a    = rand_word() & 32'hffff_fffc;
            b    = (rand_word() & 32'h0000_0ff0) | 32'(offs[i]);
            c    = rand_word();
            addr = a + b;
            load = (i >= 7);
            case (ops[i])
                exec_op_pkg::SB: data = {4{c[7:0]}};
                exec_op_pkg::SH: data = {2{c[15:0]}};
                default:         data = c;
            endcase
            drive(ops[i], a, b, c);
            @(negedge clk);
            compare("mem_address_o", mem_address, addr & 32'hffff_fffc);
            compare("mem_read_o", 32'(mem_read), 32'(load));
            compare("mem_strobe_o", 32'(mem_strobe), 32'(strobe_expect(ops[i], addr[1:0])));
            if (!load) begin
                compare("mem_write_data_o", mem_write_data, data);
            end
            commit(load, 1'b0);
        end
    endtask

    task automatic trap_case(input exec_op_pkg::op_e o, input logic ill, input logic mis,
                             input logic fault, input logic stale, input logic exp_raise,
                             input exec_trap_pkg::exc_code_e exp_code, input logic exp_we);
        drive(o, rand_word(), rand_word(), rand_word());
        exc_illegal    = ill;
        exc_misaligned = mis;
        exc_mem_fault  = fault;
        if (stale) begin
            tag = exp_tag - 1'b1;
        end
        @(negedge clk);
        compare("raise_exception_o", 32'(raise_exc), 32'(exp_raise));
        compare("exception_code_o", 32'(exc_code), 32'(exp_code));
        compare("jump_o", 32'(jump), 32'd0);
        commit(exp_we, exp_raise);
    endtask

    task automatic trap_tests();
        trap_case(exec_op_pkg::ADD, 1, 1, 1, 0, 1, exec_trap_pkg::ILLEGAL_INSTR, 0);
        trap_case(exec_op_pkg::ADD, 0, 1, 1, 0, 1, exec_trap_pkg::INSTR_MISALIGNED, 0);
        trap_case(exec_op_pkg::ECALL, 0, 0, 1, 0, 1, exec_trap_pkg::ECALL_M, 0);
        trap_case(exec_op_pkg::EBREAK, 0, 0, 1, 0, 1, exec_trap_pkg::BREAKPOINT, 0);
        // Fault without a memory access is ignored
        trap_case(exec_op_pkg::ADD, 0, 0, 1, 0, 0, exec_trap_pkg::NONE, 1);
        trap_case(exec_op_pkg::LW, 0, 0, 1, 0, 1, exec_trap_pkg::LOAD_ACCESS_FAULT, 0);
        trap_case(exec_op_pkg::SB, 0, 0, 1, 0, 1, exec_trap_pkg::LOAD_ACCESS_FAULT, 0);
        trap_case(exec_op_pkg::JAL, 1, 0, 0, 0, 1, exec_trap_pkg::ILLEGAL_INSTR, 0);
        trap_case(exec_op_pkg::ADD, 1, 0, 0, 1, 0, exec_trap_pkg::NONE, 0);
    endtask

    task automatic stall_test();
        word_t a;
        word_t b;
        a = rand_word();
        b = rand_word();
        drive(exec_op_pkg::ADD, a, b, '0);
        commit(1'b1, 1'b0);
        compare("result_o", result, a + b);
        drive(exec_op_pkg::SUB, b, a, '0);
        stall = 1'b1;
        @(posedge clk);
        #1;
        compare("result_o", result, a + b);
        compare("op_o", 32'(op_out), 32'(exec_op_pkg::ADD));
        stall = 1'b0;
        @(posedge clk);
        #1;
        compare("result_o", result, b - a);
        compare("op_o", 32'(op_out), 32'(exec_op_pkg::SUB));
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        stall          = 1'b0;
        pc             = '0;
        op_a           = '0;
        op_b           = '0;
        op_c           = '0;
        op             = exec_op_pkg::NOP;
        tag            = '0;
        exc_illegal    = 1'b0;
        exc_misaligned = 1'b0;
        exc_mem_fault  = 1'b0;
        exp_tag        = '0;
        rng            = 32'h60ac;
        errors         = 0;
        checks         = 0;
        cycles         = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        alu_tests();
        branch_tests();
        mem_tests();
        trap_tests();
        stall_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/exec_op_pkg.sv
logic/exec_trap_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/lsu_lanes.sv
logic/flow_tag.sv
logic/trap_ctrl.sv
logic/execute.sv
test/execute_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module execute_tb -f all.f \
        --Mdir obj_dir -o execute_tb_sim > build.log 2>&1; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/execute_tb_sim > sim.log 2>&1; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx '>>> PASS' sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
